/* src/eth_frame_pkg.sv */
`default_nettype none

// Word layout shared by the MAC side, the packet FIFO and the layer-2 output
package eth_frame_pkg;

	//////////////////////////////
	// MAC word fields

	// Payload bits carried per word
	localparam int data_width = 32;

	// Count of valid bytes in a word
	// 1 to 4 on data words, 0 marks a frame delimiter
	localparam int bytes_valid_width = 3;

	//////////////////////////////
	// FIFO word

	// Byte count on top, payload below
	localparam int fifo_word_width = bytes_valid_width + data_width;

	//////////////////////////////
	// Port set

	// MACs feeding the merged stream
	localparam int port_count = 2;

endpackage

`default_nettype wire

/* src/packet_fifo_pkg.sv */
`default_nettype none

// Geometry of the dual-clock packet FIFO
package packet_fifo_pkg;

	// Entries per FIFO
	// Room for two full-size frames plus their delimiters
	localparam int fifo_depth = 64;

	// Storage address bits
	localparam int fifo_addr_width = 6;

	// Read-side fill count, one bit wider than the address
	localparam int fifo_size_width = 7;

endpackage

`default_nettype wire

/* src/cdc_packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cdc_packet_fifo (
	// Write side in the MAC receive clock
	input  wire                                           wr_clk,
	input  wire                                           rst_n,
	input  wire                                           wr_en,
	input  wire [eth_frame_pkg::fifo_word_width-1:0]      wr_data,
	input  wire                                           wr_commit,
	input  wire                                           wr_rollback,
	output logic                                          wr_full,

	// Read side in the system clock
	input  wire                                           sys_clk,
	input  wire                                           rd_en,
	output logic [eth_frame_pkg::fifo_word_width-1:0]     rd_data,
	output logic [packet_fifo_pkg::fifo_size_width-1:0]   rd_size
);
	import eth_frame_pkg::*;
	import packet_fifo_pkg::*;

	logic [fifo_word_width-1:0] mem [fifo_depth];

	// Pointers carry one extra wrap bit
	logic [fifo_addr_width:0] wr_ptr;
	logic [fifo_addr_width:0] wr_ptr_committed;
	logic [fifo_addr_width:0] wr_gray_committed;
	logic [fifo_addr_width:0] rd_gray_meta;
	logic [fifo_addr_width:0] rd_gray_sync;
	logic [fifo_addr_width:0] rd_ptr_wr;

	logic [fifo_addr_width:0] rd_ptr;
	logic [fifo_addr_width:0] rd_gray;
	logic [fifo_addr_width:0] wr_gray_meta;
	logic [fifo_addr_width:0] wr_gray_sync;
	logic [fifo_addr_width:0] wr_ptr_rd;

	function automatic logic [fifo_addr_width:0] bin_to_gray(input logic [fifo_addr_width:0] bin);
		return bin ^ (bin >> 1);
	endfunction

	function automatic logic [fifo_addr_width:0] gray_to_bin(input logic [fifo_addr_width:0] gray);
		logic [fifo_addr_width:0] bin;
		bin[fifo_addr_width] = gray[fifo_addr_width];
		for (int i = fifo_addr_width - 1; i >= 0; i--) begin
			bin[i] = bin[i + 1] ^ gray[i];
		end
		return bin;
	endfunction

	//////////////////////////////
	// Write domain

	// Full when the wrap bits differ and the addresses meet
	assign rd_ptr_wr = gray_to_bin(rd_gray_sync);
	assign wr_full = (wr_ptr[fifo_addr_width] != rd_ptr_wr[fifo_addr_width])
		&& (wr_ptr[fifo_addr_width-1:0] == rd_ptr_wr[fifo_addr_width-1:0]);

	always_ff @(posedge wr_clk) begin
		if (wr_en && !wr_full) begin
			mem[wr_ptr[fifo_addr_width-1:0]] <= wr_data;
		end
	end

	// Working pointer runs ahead, committed pointer marks the last whole frame
	always_ff @(posedge wr_clk) begin
		if (!rst_n) begin
			wr_ptr            <= '0;
			wr_ptr_committed  <= '0;
			wr_gray_committed <= '0;
		end else if (wr_rollback) begin
			// Throw away everything since the last commit
			wr_ptr <= wr_ptr_committed;
		end else begin
			if (wr_en && !wr_full) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// A word written in the commit cycle belongs to the next frame
			if (wr_commit) begin
				wr_ptr_committed  <= wr_ptr;
				wr_gray_committed <= bin_to_gray(wr_ptr);
			end
		end
	end

	// Read pointer into the write clock
	always_ff @(posedge wr_clk) begin
		if (!rst_n) begin
			rd_gray_meta <= '0;
			rd_gray_sync <= '0;
		end else begin
			rd_gray_meta <= rd_gray;
			rd_gray_sync <= rd_gray_meta;
		end
	end

	//////////////////////////////
	// Read domain

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			rd_ptr  <= '0;
			rd_gray <= '0;
		end else if (rd_en) begin
			rd_ptr  <= rd_ptr + 1'b1;
			rd_gray <= bin_to_gray(rd_ptr + 1'b1);
		end
	end

	// Registered read port, data follows rd_en by one cycle
	always_ff @(posedge sys_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_ptr[fifo_addr_width-1:0]];
		end
	end

	// Committed write pointer through two flops, then back to binary
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			wr_gray_meta <= '0;
			wr_gray_sync <= '0;
			wr_ptr_rd    <= '0;
		end else begin
			wr_gray_meta <= wr_gray_committed;
			wr_gray_sync <= wr_gray_meta;
			wr_ptr_rd    <= gray_to_bin(wr_gray_sync);
		end
	end

	// Only committed words count
	assign rd_size = wr_ptr_rd - rd_ptr;

endmodule

`default_nettype wire

/* src/eth_rx_clock_crossing.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_clock_crossing (
	// Frames from the MAC
	input  wire                                          rx_clk,
	input  wire                                          rst_n,
	input  wire                                          rx_frame_start,
	input  wire                                          rx_frame_data_valid,
	input  wire [eth_frame_pkg::bytes_valid_width-1:0]   rx_frame_bytes_valid,
	input  wire [eth_frame_pkg::data_width-1:0]          rx_frame_data,
	input  wire                                          rx_frame_commit,
	input  wire                                          rx_frame_drop,

	// Frames toward the arbiter
	input  wire                                          sys_clk,
	output logic                                         frame_request,
	input  wire                                          frame_grant,
	output logic                                         frame_start,
	output logic                                         frame_data_valid,
	output logic [eth_frame_pkg::bytes_valid_width-1:0]  frame_bytes_valid,
	output logic [eth_frame_pkg::data_width-1:0]         frame_data,
	output logic                                         frame_commit
);
	import eth_frame_pkg::*;
	import packet_fifo_pkg::*;

	logic                         fifo_wr_en;
	logic [fifo_word_width-1:0]   fifo_wr_data;
	logic                         fifo_wr_full;
	logic                         fifo_rd_en;
	logic [fifo_word_width-1:0]   fifo_rd_data;
	logic [fifo_size_width-1:0]   fifo_rd_size;
	logic [bytes_valid_width-1:0] rd_bytes_valid;
	logic [data_width-1:0]        rd_word;

	enum logic [2:0] {
		st_wait_delim  = 3'd0,
		st_check_delim = 3'd1,
		st_idle        = 3'd2,
		st_request     = 3'd3,
		st_stream      = 3'd4,
		st_final       = 3'd5
	} pop_state;

	// Full flag is watched by the bound checks
	cdc_packet_fifo i_cdc_packet_fifo (
		.wr_clk      (rx_clk),
		.rst_n       (rst_n),
		.wr_en       (fifo_wr_en),
		.wr_data     (fifo_wr_data),
		.wr_commit   (rx_frame_commit),
		.wr_rollback (rx_frame_drop),
		.wr_full     (fifo_wr_full),
		.sys_clk     (sys_clk),
		.rd_en       (fifo_rd_en),
		.rd_data     (fifo_rd_data),
		.rd_size     (fifo_rd_size)
	);

	//////////////////////////////
	// Push side

	// Start strobe writes the all-zero delimiter
	always_comb begin
		if (rx_frame_start) begin
			fifo_wr_en   = 1'b1;
			fifo_wr_data = '0;
		end else begin
			fifo_wr_en   = rx_frame_data_valid;
			fifo_wr_data = {rx_frame_bytes_valid, rx_frame_data};
		end
	end

	//////////////////////////////
	// Pop side

	assign {rd_bytes_valid, rd_word} = fifo_rd_data;

	assign frame_request = (pop_state == st_request);

	// Read one word ahead while the current one goes out
	always_comb begin
		case (pop_state)
			st_wait_delim: fifo_rd_en = (fifo_rd_size != 0);
			st_request:    fifo_rd_en = frame_grant;
			st_stream:     fifo_rd_en = (rd_bytes_valid != 0) && (fifo_rd_size != 0);
			default:       fifo_rd_en = 1'b0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			pop_state        <= st_wait_delim;
			frame_start      <= 1'b0;
			frame_data_valid <= 1'b0;
			frame_commit     <= 1'b0;
		end else begin
			frame_start      <= 1'b0;
			frame_data_valid <= 1'b0;
			frame_commit     <= 1'b0;
			case (pop_state)
				// First frame after reset
				st_wait_delim: begin
					if (fifo_rd_size != 0) begin
						pop_state <= st_check_delim;
					end
				end
				// Anything but a delimiter is stray data and gets skipped
				st_check_delim: begin
					if (rd_bytes_valid == 0) begin
						pop_state <= st_idle;
					end else begin
						pop_state <= st_wait_delim;
					end
				end
				// Words past the delimiter mean a whole committed frame
				st_idle: begin
					if (fifo_rd_size != 0) begin
						pop_state <= st_request;
					end
				end
				// First word read is issued with the grant
				st_request: begin
					if (frame_grant) begin
						frame_start <= 1'b1;
						pop_state   <= st_stream;
					end
				end
				st_stream: begin
					if (rd_bytes_valid == 0) begin
						// Next frame's delimiter is already consumed
						frame_commit <= 1'b1;
						pop_state    <= st_idle;
					end else begin
						frame_data_valid <= 1'b1;
						if (fifo_rd_size == 0) begin
							pop_state <= st_final;
						end
					end
				end
				// FIFO ran dry on the last word
				st_final: begin
					frame_commit <= 1'b1;
					pop_state    <= st_wait_delim;
				end
				default: pop_state <= st_wait_delim;
			endcase
		end
	end

	// Output payload
	always_ff @(posedge sys_clk) begin
		if (pop_state == st_stream) begin
			frame_bytes_valid <= rd_bytes_valid;
			frame_data        <= rd_word;
		end
	end

endmodule

`default_nettype wire

/* src/rx_frame_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_frame_arbiter (
	input  wire                                              sys_clk,
	input  wire                                              rst_n,

	// Request and grant per port
	input  wire                                              frame_request_0,
	input  wire                                              frame_request_1,
	output logic                                             frame_grant_0,
	output logic                                             frame_grant_1,

	// Port 0 stream
	input  wire                                              frame_start_0,
	input  wire                                              frame_data_valid_0,
	input  wire [eth_frame_pkg::bytes_valid_width-1:0]       frame_bytes_valid_0,
	input  wire [eth_frame_pkg::data_width-1:0]              frame_data_0,
	input  wire                                              frame_commit_0,

	// Port 1 stream
	input  wire                                              frame_start_1,
	input  wire                                              frame_data_valid_1,
	input  wire [eth_frame_pkg::bytes_valid_width-1:0]       frame_bytes_valid_1,
	input  wire [eth_frame_pkg::data_width-1:0]              frame_data_1,
	input  wire                                              frame_commit_1,

	// Merged stream to layer 2
	output logic                                             out_frame_start,
	output logic                                             out_frame_data_valid,
	output logic [eth_frame_pkg::bytes_valid_width-1:0]      out_frame_bytes_valid,
	output logic [eth_frame_pkg::data_width-1:0]             out_frame_data,
	output logic                                             out_frame_commit,
	output logic [$clog2(eth_frame_pkg::port_count)-1:0]     out_frame_port
);
	import eth_frame_pkg::*;

	logic                          busy;
	logic [$clog2(port_count)-1:0] owner;
	// Set when port 1 wins a tie
	logic                          favored;

	// Grant only between frames
	assign frame_grant_0 = !busy && frame_request_0 && (!frame_request_1 || !favored);
	assign frame_grant_1 = !busy && frame_request_1 && (!frame_request_0 || favored);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			owner   <= '0;
			favored <= 1'b0;
		end else if (busy) begin
			if (out_frame_commit) begin
				busy <= 1'b0;
			end
		end else if (frame_grant_0 || frame_grant_1) begin
			busy    <= 1'b1;
			owner   <= frame_grant_1;
			// Other port goes first next time
			favored <= frame_grant_0;
		end
	end

	// Owner's stream passes straight through
	always_comb begin
		if (owner != '0) begin
			out_frame_start       = frame_start_1;
			out_frame_data_valid  = frame_data_valid_1;
			out_frame_bytes_valid = frame_bytes_valid_1;
			out_frame_data        = frame_data_1;
			out_frame_commit      = frame_commit_1;
		end else begin
			out_frame_start       = frame_start_0;
			out_frame_data_valid  = frame_data_valid_0;
			out_frame_bytes_valid = frame_bytes_valid_0;
			out_frame_data        = frame_data_0;
			out_frame_commit      = frame_commit_0;
		end
	end

	assign out_frame_port = owner;

endmodule

`default_nettype wire

/* src/eth_rx_dual_port.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_dual_port (
	input  wire                                            sys_clk,
	input  wire                                            rst_n,

	// MAC port 0
	input  wire                                            rx_clk_0,
	input  wire                                            rx_frame_start_0,
	input  wire                                            rx_frame_data_valid_0,
	input  wire [eth_frame_pkg::bytes_valid_width-1:0]     rx_frame_bytes_valid_0,
	input  wire [eth_frame_pkg::data_width-1:0]            rx_frame_data_0,
	input  wire                                            rx_frame_commit_0,
	input  wire                                            rx_frame_drop_0,

	// MAC port 1
	input  wire                                            rx_clk_1,
	input  wire                                            rx_frame_start_1,
	input  wire                                            rx_frame_data_valid_1,
	input  wire [eth_frame_pkg::bytes_valid_width-1:0]     rx_frame_bytes_valid_1,
	input  wire [eth_frame_pkg::data_width-1:0]            rx_frame_data_1,
	input  wire                                            rx_frame_commit_1,
	input  wire                                            rx_frame_drop_1,

	// Tagged stream to the layer-2 decoder
	output wire                                            frame_start,
	output wire                                            frame_data_valid,
	output wire [eth_frame_pkg::bytes_valid_width-1:0]     frame_bytes_valid,
	output wire [eth_frame_pkg::data_width-1:0]            frame_data,
	output wire                                            frame_commit,
	output wire [$clog2(eth_frame_pkg::port_count)-1:0]    frame_port
);
	import eth_frame_pkg::*;

	logic                         request_0;
	logic                         grant_0;
	logic                         start_0;
	logic                         data_valid_0;
	logic [bytes_valid_width-1:0] bytes_valid_0;
	logic [data_width-1:0]        data_0;
	logic                         commit_0;

	logic                         request_1;
	logic                         grant_1;
	logic                         start_1;
	logic                         data_valid_1;
	logic [bytes_valid_width-1:0] bytes_valid_1;
	logic [data_width-1:0]        data_1;
	logic                         commit_1;

	//////////////////////////////
	// Per-port clock crossings

	eth_rx_clock_crossing i_eth_rx_clock_crossing_0 (
		.rx_clk               (rx_clk_0),
		.rst_n                (rst_n),
		.rx_frame_start       (rx_frame_start_0),
		.rx_frame_data_valid  (rx_frame_data_valid_0),
		.rx_frame_bytes_valid (rx_frame_bytes_valid_0),
		.rx_frame_data        (rx_frame_data_0),
		.rx_frame_commit      (rx_frame_commit_0),
		.rx_frame_drop        (rx_frame_drop_0),
		.sys_clk              (sys_clk),
		.frame_request        (request_0),
		.frame_grant          (grant_0),
		.frame_start          (start_0),
		.frame_data_valid     (data_valid_0),
		.frame_bytes_valid    (bytes_valid_0),
		.frame_data           (data_0),
		.frame_commit         (commit_0)
	);

	eth_rx_clock_crossing i_eth_rx_clock_crossing_1 (
		.rx_clk               (rx_clk_1),
		.rst_n                (rst_n),
		.rx_frame_start       (rx_frame_start_1),
		.rx_frame_data_valid  (rx_frame_data_valid_1),
		.rx_frame_bytes_valid (rx_frame_bytes_valid_1),
		.rx_frame_data        (rx_frame_data_1),
		.rx_frame_commit      (rx_frame_commit_1),
		.rx_frame_drop        (rx_frame_drop_1),
		.sys_clk              (sys_clk),
		.frame_request        (request_1),
		.frame_grant          (grant_1),
		.frame_start          (start_1),
		.frame_data_valid     (data_valid_1),
		.frame_bytes_valid    (bytes_valid_1),
		.frame_data           (data_1),
		.frame_commit         (commit_1)
	);

	//////////////////////////////
	// Merge

	rx_frame_arbiter i_rx_frame_arbiter (
		.sys_clk               (sys_clk),
		.rst_n                 (rst_n),
		.frame_request_0       (request_0),
		.frame_request_1       (request_1),
		.frame_grant_0         (grant_0),
		.frame_grant_1         (grant_1),
		.frame_start_0         (start_0),
		.frame_data_valid_0    (data_valid_0),
		.frame_bytes_valid_0   (bytes_valid_0),
		.frame_data_0          (data_0),
		.frame_commit_0        (commit_0),
		.frame_start_1         (start_1),
		.frame_data_valid_1    (data_valid_1),
		.frame_bytes_valid_1   (bytes_valid_1),
		.frame_data_1          (data_1),
		.frame_commit_1        (commit_1),
		.out_frame_start       (frame_start),
		.out_frame_data_valid  (frame_data_valid),
		.out_frame_bytes_valid (frame_bytes_valid),
		.out_frame_data        (frame_data),
		.out_frame_commit      (frame_commit),
		.out_frame_port        (frame_port)
	);

endmodule

`default_nettype wire

/* test/eth_rx_dual_port_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_rx_dual_port_assert (
	input wire rx_clk,
	input wire sys_clk,
	input wire rst_n,
	input wire fifo_wr_en,
	input wire fifo_wr_full,
	input wire frame_request,
	input wire frame_grant,
	input wire frame_start,
	input wire frame_data_valid,
	input wire frame_commit
);

	// Open between frame_start and frame_commit
	logic in_frame;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			in_frame <= 1'b0;
		end else if (frame_start) begin
			in_frame <= 1'b1;
		end else if (frame_commit) begin
			in_frame <= 1'b0;
		end
	end

	//////////////////////////////
	// Push side

	// Frames are sized to fit, a write into a full FIFO would be lost
	assert property (@(posedge rx_clk) disable iff (!rst_n) !(fifo_wr_en && fifo_wr_full))
		else $error("FIFO write while full");

	//////////////////////////////
	// Pop side

	// Request stays up until the arbiter answers
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		frame_request && !frame_grant |=> frame_request)
		else $error("Frame request dropped before its grant");

	// Data only inside a started frame
	assert property (@(posedge sys_clk) disable iff (!rst_n)
		frame_data_valid |-> in_frame && !frame_start)
		else $error("Data valid outside a frame");

endmodule

// Checks bound into each port crossing
bind eth_rx_clock_crossing eth_rx_dual_port_assert i_eth_rx_dual_port_assert (
	.rx_clk           (rx_clk),
	.sys_clk          (sys_clk),
	.rst_n            (rst_n),
	.fifo_wr_en       (fifo_wr_en),
	.fifo_wr_full     (fifo_wr_full),
	.frame_request    (frame_request),
	.frame_grant      (frame_grant),
	.frame_start      (frame_start),
	.frame_data_valid (frame_data_valid),
	.frame_commit     (frame_commit)
);

`default_nettype wire

/* test/tb_eth_rx_dual_port.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_rx_dual_port;
	import eth_frame_pkg::*;

	localparam int frames_per_port = 40;
	localparam int max_words = 16;
	localparam int check_count = 5;
	// 20 rx cycles of 10 ns per frame, 2.5 sys cycles each, plus margin
	localparam int timeout_cycles = frames_per_port * 20 * 5 / 2 + 2000;

	logic                         sys_clk;
	logic                         rst_n;
	logic                         rx_clk [port_count];
	logic                         rx_start [port_count];
	logic                         rx_valid [port_count];
	logic [bytes_valid_width-1:0] rx_bytes [port_count];
	logic [data_width-1:0]        rx_data [port_count];
	logic                         rx_commit [port_count];
	logic                         rx_drop [port_count];

	wire                                frame_start;
	wire                                frame_data_valid;
	wire [bytes_valid_width-1:0]        frame_bytes_valid;
	wire [data_width-1:0]               frame_data;
	wire                                frame_commit;
	wire [$clog2(port_count)-1:0]       frame_port;

	// Stimulus tables, filled once from the seed
	logic [data_width-1:0]        stim_data [port_count][frames_per_port][max_words];
	int                           stim_len [port_count][frames_per_port];
	logic [bytes_valid_width-1:0] stim_last [port_count][frames_per_port];
	bit                           stim_drop [port_count][frames_per_port];
	int                           stim_gap [port_count][frames_per_port];
	integer                       seed;

	// Model, committed frames in MAC order
	logic [fifo_word_width-1:0] exp_words [port_count][$];
	int                         exp_len [port_count][$];

	// Monitor state
	logic [fifo_word_width-1:0]   got_words [$];
	bit                           in_frame;
	logic [$clog2(port_count)-1:0] frame_owner;
	bit                           contended;
	bit                           any_commit;
	bit                           port_done [port_count];
	int                           delivered [port_count];
	int                           contended_ok;
	int                           errors [check_count];
	string check_names [check_count] = '{"reset_quiet", "frame_content", "dropped_frames",
		"frame_framing", "port_contention"};

	eth_rx_dual_port i_eth_rx_dual_port (
		.sys_clk                (sys_clk),
		.rst_n                  (rst_n),
		.rx_clk_0               (rx_clk[0]),
		.rx_frame_start_0       (rx_start[0]),
		.rx_frame_data_valid_0  (rx_valid[0]),
		.rx_frame_bytes_valid_0 (rx_bytes[0]),
		.rx_frame_data_0        (rx_data[0]),
		.rx_frame_commit_0      (rx_commit[0]),
		.rx_frame_drop_0        (rx_drop[0]),
		.rx_clk_1               (rx_clk[1]),
		.rx_frame_start_1       (rx_start[1]),
		.rx_frame_data_valid_1  (rx_valid[1]),
		.rx_frame_bytes_valid_1 (rx_bytes[1]),
		.rx_frame_data_1        (rx_data[1]),
		.rx_frame_commit_1      (rx_commit[1]),
		.rx_frame_drop_1        (rx_drop[1]),
		.frame_start            (frame_start),
		.frame_data_valid       (frame_data_valid),
		.frame_bytes_valid      (frame_bytes_valid),
		.frame_data             (frame_data),
		.frame_commit           (frame_commit),
		.frame_port             (frame_port)
	);

	//////////////////////////////
	// Stimulus and model

	// Only the last word of a frame may be partial
	function automatic logic [bytes_valid_width-1:0] bytes_for_word(input int p, input int f,
		input int w);
		if (w == stim_len[p][f] - 1) begin
			return stim_last[p][f];
		end
		return 3'd4;
	endfunction

	task automatic build_stimulus();
		for (int p = 0; p < port_count; p++) begin
			for (int f = 0; f < frames_per_port; f++) begin
				stim_len[p][f]  = 1 + ($unsigned($random(seed)) % max_words);
				stim_last[p][f] = 1 + ($unsigned($random(seed)) % 4);
				stim_drop[p][f] = ($unsigned($random(seed)) % 5) == 0;
				stim_gap[p][f]  = 2 + ($unsigned($random(seed)) % 12);
				for (int w = 0; w < stim_len[p][f]; w++) begin
					stim_data[p][f][w] = $random(seed);
				end
				// Dropped frames never reach the model
				if (!stim_drop[p][f]) begin
					exp_len[p].push_back(stim_len[p][f]);
					for (int w = 0; w < stim_len[p][f]; w++) begin
						exp_words[p].push_back({bytes_for_word(p, f, w), stim_data[p][f][w]});
					end
				end
			end
		end
	endtask

	// One MAC per port, each in its own clock
	for (genvar p = 0; p < port_count; p++) begin : g_port
		// Port 0 at 10 ns, port 1 at 6 ns
		initial begin
			rx_clk[p] = 1'b0;
			forever #(p == 0 ? 5 : 3) rx_clk[p] = ~rx_clk[p];
		end

		initial begin
			rx_start[p]  = 1'b0;
			rx_valid[p]  = 1'b0;
			rx_bytes[p]  = '0;
			rx_data[p]   = '0;
			rx_commit[p] = 1'b0;
			rx_drop[p]   = 1'b0;
			port_done[p] = 1'b0;
			wait (rst_n === 1'b1);
			repeat (4) @(posedge rx_clk[p]);
			for (int f = 0; f < frames_per_port; f++) begin
				@(posedge rx_clk[p]);
				rx_start[p] <= 1'b1;
				for (int w = 0; w < stim_len[p][f]; w++) begin
					@(posedge rx_clk[p]);
					rx_start[p] <= 1'b0;
					rx_valid[p] <= 1'b1;
					rx_bytes[p] <= bytes_for_word(p, f, w);
					rx_data[p]  <= stim_data[p][f][w];
				end
				@(posedge rx_clk[p]);
				rx_valid[p]  <= 1'b0;
				rx_commit[p] <= !stim_drop[p][f];
				rx_drop[p]   <= stim_drop[p][f];
				if (!stim_drop[p][f]) begin
					any_commit = 1'b1;
				end
				@(posedge rx_clk[p]);
				rx_commit[p] <= 1'b0;
				rx_drop[p]   <= 1'b0;
				repeat (stim_gap[p][f]) @(posedge rx_clk[p]);
			end
			port_done[p] = 1'b1;
		end
	end

	//////////////////////////////
	// Output monitor

	// Compare a finished frame with the head of its port's queue
	task automatic check_frame();
		int p;
		int n;
		bit ok;
		logic [fifo_word_width-1:0] exp_word;
		p  = frame_owner;
		ok = 1'b1;
		assert (exp_len[p].size() != 0) else begin
			$display("Frame on port %0d with no committed frame left to match", p);
			errors[2]++;
		end
		if (exp_len[p].size() == 0) begin
			return;
		end
		n = exp_len[p].pop_front();
		assert (got_words.size() == n) else begin
			$display("Mismatch frame_content port %0d frame %0d length expected %0d actual %0d",
				p, delivered[p], n, got_words.size());
			errors[1]++;
			ok = 1'b0;
		end
		for (int i = 0; i < n; i++) begin
			exp_word = exp_words[p].pop_front();
			assert (i >= got_words.size() || got_words[i] === exp_word) else begin
				$display("Mismatch frame_content port %0d frame %0d word %0d expected %h actual %h",
					p, delivered[p], i, exp_word, got_words[i]);
				errors[1]++;
				ok = 1'b0;
			end
		end
		delivered[p]++;
		if (contended && ok) begin
			contended_ok++;
		end
	endtask

	// Sampled on the falling edge, away from every clock's rising edge
	always @(negedge sys_clk) begin
		if (rst_n === 1'b1) begin
			if (!any_commit) begin
				assert (frame_start === 1'b0 && frame_data_valid === 1'b0 && frame_commit === 1'b0)
				else begin
					$display("Output became active before any frame was committed");
					errors[0]++;
				end
			end
			if (frame_start === 1'b1) begin
				assert (!in_frame && frame_data_valid !== 1'b1 && frame_commit !== 1'b1) else begin
					$display("Frame start arrived inside a running frame");
					errors[3]++;
				end
				in_frame    = 1'b1;
				frame_owner = frame_port;
				contended   = 1'b0;
				got_words.delete();
			end else if (in_frame) begin
				// Other port waiting means the merge is under contention
				if ((frame_owner == 0) ? i_eth_rx_dual_port.request_1
					: i_eth_rx_dual_port.request_0) begin
					contended = 1'b1;
				end
				assert (frame_port === frame_owner) else begin
					$display("Mismatch frame_content frame_port expected %0d actual %0d",
						frame_owner, frame_port);
					errors[1]++;
				end
				assert (frame_data_valid === 1'b1 || frame_commit === 1'b1) else begin
					$display("Gap without data inside a frame from port %0d", frame_owner);
					errors[3]++;
				end
				if (frame_data_valid === 1'b1) begin
					got_words.push_back({frame_bytes_valid, frame_data});
				end else if (frame_commit === 1'b1) begin
					in_frame = 1'b0;
					check_frame();
				end
			end else begin
				assert (frame_data_valid !== 1'b1 && frame_commit !== 1'b1) else begin
					$display("Data valid or commit outside a frame");
					errors[3]++;
				end
			end
		end
	end

	//////////////////////////////
	// Clock, reset and report

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		int cycles;
		int total;
		bit finished;
		rst_n      = 1'b0;
		seed       = 32'h9c59bdf4;
		any_commit = 1'b0;
		build_stimulus();
		repeat (10) @(posedge sys_clk);
		rst_n <= 1'b1;
		cycles   = 0;
		finished = 1'b0;
		while (!finished && cycles < timeout_cycles) begin
			@(posedge sys_clk);
			cycles++;
			finished = port_done[0] && port_done[1]
				&& exp_len[0].size() == 0 && exp_len[1].size() == 0;
		end
		if (!finished) begin
			$display("Timeout after %0d cycles, committed frames are missing from the output",
				cycles);
			errors[1]++;
		end else begin
			// A leaked dropped frame would show up here
			repeat (50) @(posedge sys_clk);
		end
		assert (exp_len[0].size() == 0 && exp_len[1].size() == 0) else begin
			$display("Frames never delivered, port 0 missing %0d, port 1 missing %0d",
				exp_len[0].size(), exp_len[1].size());
			errors[2]++;
		end
		assert (delivered[0] > 0 && delivered[1] > 0 && contended_ok > 0) else begin
			$display("No frame was merged correctly while the other port was waiting");
			errors[4]++;
		end
		total = 0;
		for (int i = 0; i < check_count; i++) begin
			$display("Check %0d %s: %s, %0d errors", i + 1, check_names[i],
				(errors[i] == 0) ? "ok" : "FAILED", errors[i]);
			total += errors[i];
		end
		$display("Frames port 0 %0d, port 1 %0d, contended %0d, errors %0d",
			delivered[0], delivered[1], contended_ok, total);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
src/eth_frame_pkg.sv
src/packet_fifo_pkg.sv
src/cdc_packet_fifo.sv
src/eth_rx_clock_crossing.sv
src/rx_frame_arbiter.sv
src/eth_rx_dual_port.sv
test/eth_rx_dual_port_assert.sv
test/tb_eth_rx_dual_port.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dual-port receive testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_eth_rx_dual_port -f verilog.f -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Checks failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation OK"
